// File: verilog/cycleTerm_config.svh
////////////////////////////////////////
// Address map and timing constants for the cycle termination block
// Windows are base plus mask, so each size must be a power of two
// CIA_HALF_PERIOD below 4 hides CIA clock levels from the synchronizer
////////////////////////////////////////
`ifndef CYCLETERM_CONFIG_SVH
`define CYCLETERM_CONFIG_SVH

// Kickstart ROM, 512K at the top of the 24-bit space
`define ROM_BASE        32'h00F8_0000
`define ROM_MASK        32'hFFF8_0000
// Both CIAs share one 64K window, A12 and A13 pick the chip
`define CIA_BASE        32'h00BF_0000
`define CIA_MASK        32'hFFFF_0000
`define CHIP_BASE       32'h0000_0000
`define CHIP_MASK       32'hFFE0_0000
`define REG_BASE        32'h00DF_0000
`define REG_MASK        32'hFFFF_0000
`define FAST_BASE       32'h0800_0000
`define FAST_MASK       32'hF800_0000

// Clocks from ROM cycle start to acknowledge, fits the 2-bit counter
`define ROM_WAIT        4
`define CIA_HALF_PERIOD 6
`define IACK_TT         2'd3

`endif

// File: verilog/cycleTermPkg.sv
////////////////////////////////////////
// Shared types for the cycle termination block
// Widths follow the 68040 local bus
////////////////////////////////////////
package cycleTermPkg;

    // Full 32-bit bus address
    typedef logic [31:0] addr_t;

    // Transfer type from the processor
    // Value 3 is interrupt acknowledge
    typedef logic [1:0] tt_t;

    // ROM setup delay counter
    typedef logic [1:0] romCount_t;

    // Two-stage history of the sampled CIA clock
    typedef logic [1:0] ciaSync_t;

    // CIA acknowledge FSM
    // Idle waits for a CIA cycle with the clock high, armed waits for it to fall
    typedef enum logic {
        ciaIdle,
        ciaArmed
    } ciaAckState_t;

endpackage

// File: verilog/addressDecode.sv
////////////////////////////////////////
// Purely combinational, flags settle with the address
// An interrupt acknowledge masks every space flag and select
// Chip selects and ROM enable follow ts, the space flags do not
////////////////////////////////////////
`include "cycleTerm_config.svh"

module addressDecode (
    input  cycleTermPkg::addr_t address,
    input  cycleTermPkg::tt_t   tt,
    input  logic                ts,
    output logic                romSpace,
    output logic                ciaSpace,
    output logic                ciaEnable,
    output logic                autoVector,
    output logic                knownAddress,
    output logic                nRomEn,
    output logic                nCiaCsA,
    output logic                nCiaCsB
);

    // Raw window hits
    logic romHit;
    logic ciaHit;
    logic chipHit;
    logic regHit;
    logic fastHit;
    // CIA selects before ts gating, active high
    logic ciaSelA;
    logic ciaSelB;

    ////////////////////////////////////////
    // Window compare
    ////////////////////////////////////////

    assign romHit  = (address & `ROM_MASK)  == `ROM_BASE;
    assign ciaHit  = (address & `CIA_MASK)  == `CIA_BASE;
    assign chipHit = (address & `CHIP_MASK) == `CHIP_BASE;
    assign regHit  = (address & `REG_MASK)  == `REG_BASE;
    assign fastHit = (address & `FAST_MASK) == `FAST_BASE;

    // Any of the five windows, whatever tt says
    assign knownAddress = romHit | ciaHit | chipHit | regHit | fastHit;

    // Autovector cycles carry the interrupt level on the address bus
    assign autoVector = (tt == `IACK_TT);

    // Spaces this block may terminate, never during an IACK
    assign romSpace = romHit & ~autoVector;
    assign ciaSpace = ciaHit & ~autoVector;

    ////////////////////////////////////////
    // CIA chip select
    ////////////////////////////////////////

    // CIA A sits on A12 low
    assign ciaSelA = ciaSpace & ~address[12];
    // CIA B sits on A13 low
    assign ciaSelB = ciaSpace & ~address[13];

    // Exactly one chip may be selected for the cycle to be acked
    assign ciaEnable = ciaSelA ^ ciaSelB;

    ////////////////////////////////////////
    // Board enables, active low
    ////////////////////////////////////////

    assign nRomEn  = ~(romSpace & ts);
    assign nCiaCsA = ~(ciaSelA & ts);
    assign nCiaCsB = ~(ciaSelB & ts);

endmodule

// File: verilog/ciaClockGen.sv
////////////////////////////////////////
// Free-running CIA clock, low out of reset
// Period is twice CIA_HALF_PERIOD cycles of CLK40
////////////////////////////////////////
`include "cycleTerm_config.svh"

module ciaClockGen (
    input  logic CLK40,
    input  logic nRESET,
    output logic ciaClk
);

    // Enough bits to hold CIA_HALF_PERIOD - 1
    localparam int DivWidth = $clog2(`CIA_HALF_PERIOD);
    localparam logic [DivWidth-1:0] DivLast = DivWidth'(`CIA_HALF_PERIOD - 1);

    logic [DivWidth-1:0] divCount;

    ////////////////////////////////////////
    // Half-period divider
    ////////////////////////////////////////

    // Toggle on the last count of each half
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            divCount <= '0;
            ciaClk   <= 1'b0;
        end else begin
            if (divCount == DivLast) begin
                divCount <= '0;
                ciaClk   <= ~ciaClk;
            end else begin
                divCount <= divCount + 1'b1;
            end
        end
    end

endmodule

// File: verilog/transferAck.sv
////////////////////////////////////////
// nTA for ROM, CIA, autovector and unmapped cycles only
// taOe goes to the pad tri-state, RAM and register cycles are acked elsewhere
// The master must drop ts the cycle after it sees nTA low
////////////////////////////////////////
`include "cycleTerm_config.svh"

module transferAck (
    input  logic CLK40,
    input  logic nRESET,
    input  logic ts,
    input  logic romSpace,
    input  logic ciaSpace,
    input  logic ciaEnable,
    input  logic autoVector,
    input  logic knownAddress,
    input  logic ciaClk,
    output logic nTA,
    output logic taOe
);

    // Counter value seen on the edge that fires the ROM ack
    localparam cycleTermPkg::romCount_t RomLast = cycleTermPkg::romCount_t'(`ROM_WAIT - 1);

    // ROM delay
    cycleTermPkg::romCount_t romCount;
    logic                    romTa;
    logic                    romDone;
    // Short cycle shifter, bit 1 is the ack
    logic [1:0]              shortTa;
    logic                    shortCycle;
    // CIA clock sampling and ack
    cycleTermPkg::ciaSync_t     ciaSync;
    cycleTermPkg::ciaAckState_t ciaState;
    logic                       ciaTa;

    ////////////////////////////////////////
    // Transfer acknowledge output
    ////////////////////////////////////////

    assign nTA = ~(romTa | shortTa[1] | ciaTa);

    // Drive the pad only for spaces terminated here
    assign taOe = ts & (romSpace | ciaSpace | autoVector | ~knownAddress);

    ////////////////////////////////////////
    // ROM setup delay
    ////////////////////////////////////////

    // Counts from the first edge with ts high in ROM space
    // romDone stops a second ack if ts is held past the ack
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            romCount <= '0;
            romTa    <= 1'b0;
            romDone  <= 1'b0;
        end else begin
            if (!(ts && romSpace)) begin
                romCount <= '0;
                romTa    <= 1'b0;
                romDone  <= 1'b0;
            end else if (romDone) begin
                // One cycle only
                romTa <= 1'b0;
            end else if (romCount == RomLast) begin
                romTa   <= 1'b1;
                romDone <= 1'b1;
            end else begin
                romCount <= romCount + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Short cycle ack
    ////////////////////////////////////////

    // IACK gets its vector from autovectoring, unmapped cycles end at once
    assign shortCycle = ts & (autoVector | ~knownAddress);

    // Single one walks out of bit 1 after edge 2 and stays out
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            shortTa <= 2'b01;
        end else begin
            if (shortCycle) begin
                shortTa <= shortTa << 1;
            end else begin
                shortTa <= 2'b01;
            end
        end
    end

    ////////////////////////////////////////
    // CIA ack
    ////////////////////////////////////////

    // CIA data is valid at the falling edge of its clock
    // Arm on a steady high, ack one clock after a steady low
    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            ciaSync  <= '0;
            ciaState <= cycleTermPkg::ciaIdle;
            ciaTa    <= 1'b0;
        end else begin
            // History restarts with each cycle
            // Clock levels from before ts never arm the ack
            if (ts) begin
                ciaSync <= {ciaSync[0], ciaClk};
            end else begin
                ciaSync <= '0;
            end
            ciaTa   <= 1'b0;
            case (ciaState)
                cycleTermPkg::ciaIdle: begin
                    if (ciaSync == 2'b11 && ciaEnable && ts) begin
                        ciaState <= cycleTermPkg::ciaArmed;
                    end
                end
                cycleTermPkg::ciaArmed: begin
                    if (!ts) begin
                        // Cycle went away, do not ack the next one
                        ciaState <= cycleTermPkg::ciaIdle;
                    end else if (ciaSync == 2'b00) begin
                        ciaTa    <= 1'b1;
                        ciaState <= cycleTermPkg::ciaIdle;
                    end
                end
                default: ciaState <= cycleTermPkg::ciaIdle;
            endcase
        end
    end

endmodule

// File: verilog/cycleTermTop.sv
////////////////////////////////////////
// Cycle termination for a 68040 local bus
// nTA is only valid while taOe is high, the pad does the tri-state
////////////////////////////////////////

module cycleTermTop (
    input  logic                CLK40,
    input  logic                nRESET,
    input  logic                ts,
    input  cycleTermPkg::addr_t address,
    input  cycleTermPkg::tt_t   tt,
    output logic                nTA,
    output logic                taOe,
    output logic                nRomEn,
    output logic                nCiaCsA,
    output logic                nCiaCsB,
    output logic                ciaClk
);

    // Decode flags into the ack block
    logic romSpace;
    logic ciaSpace;
    logic ciaEnable;
    logic autoVector;
    logic knownAddress;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////

    addressDecode uDecode (
        .address      (address),
        .tt           (tt),
        .ts           (ts),
        .romSpace     (romSpace),
        .ciaSpace     (ciaSpace),
        .ciaEnable    (ciaEnable),
        .autoVector   (autoVector),
        .knownAddress (knownAddress),
        .nRomEn       (nRomEn),
        .nCiaCsA      (nCiaCsA),
        .nCiaCsB      (nCiaCsB)
    );

    ////////////////////////////////////////
    // CIA clock
    ////////////////////////////////////////

    // Also used for the E clock timing of the CIA cycles
    ciaClockGen uCiaClk (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .ciaClk (ciaClk)
    );

    ////////////////////////////////////////
    // Transfer acknowledge
    ////////////////////////////////////////

    transferAck uAck (
        .CLK40        (CLK40),
        .nRESET       (nRESET),
        .ts           (ts),
        .romSpace     (romSpace),
        .ciaSpace     (ciaSpace),
        .ciaEnable    (ciaEnable),
        .autoVector   (autoVector),
        .knownAddress (knownAddress),
        .ciaClk       (ciaClk),
        .nTA          (nTA),
        .taOe         (taOe)
    );

endmodule

// File: sim/tbCycleTerm.sv
////////////////////////////////////////
// Inputs change 2 units after the rising edge, outputs are sampled on the falling edge
// Bus cycles follow the master rule, ts drops the cycle after nTA is seen low
// CIA latency is judged from the CIA clock levels, not from a fixed count
////////////////////////////////////////
`include "cycleTerm_config.svh"

module tbCycleTerm;

    localparam int ClkHalf      = 20;
    localparam int DriveDelay   = 2;
    localparam int ResetCycles  = 10;
    localparam int RandomCycles = 40;
    // 13 directed bus cycles ahead of the random mix
    localparam int NumBusCycles   = 13 + RandomCycles;
    localparam int WatchdogCycles = 60 * (NumBusCycles + 1);
    // Four full CIA clock periods
    localparam int CiaLimit = 8 * `CIA_HALF_PERIOD;

    // Space classes of the reference model
    localparam int SpRom    = 0;
    localparam int SpCia    = 1;
    localparam int SpCiaBad = 2;
    localparam int SpRam    = 3;
    localparam int SpShort  = 4;

    logic                CLK40;
    logic                nRESET;
    logic                ts;
    cycleTermPkg::addr_t address;
    cycleTermPkg::tt_t   tt;
    logic                nTA;
    logic                taOe;
    logic                nRomEn;
    logic                nCiaCsA;
    logic                nCiaCsB;
    logic                ciaClk;

    int errorCount = 0;
    int checkCount = 0;

    cycleTermTop dut (
        .CLK40   (CLK40),
        .nRESET  (nRESET),
        .ts      (ts),
        .address (address),
        .tt      (tt),
        .nTA     (nTA),
        .taOe    (taOe),
        .nRomEn  (nRomEn),
        .nCiaCsA (nCiaCsA),
        .nCiaCsB (nCiaCsB),
        .ciaClk  (ciaClk)
    );

    ////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////

    initial begin
        CLK40 = 1'b0;
        forever #ClkHalf CLK40 = ~CLK40;
    end

    // About 60 clocks per bus cycle covers the slowest CIA case
    initial begin
        repeat (WatchdogCycles) @(posedge CLK40);
        $display("Timeout: the run did not finish within %0d clock cycles", WatchdogCycles);
        $display("Checks: %0d  Errors: %0d", checkCount, errorCount + 1);
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////
    // Bus rules checked on every edge
    ////////////////////////////////////////

    // With ts low nothing is acked, driven or selected
    idleQuiet: assert property (@(posedge CLK40) disable iff (!nRESET)
        !ts |-> (nTA && !taOe && nRomEn && nCiaCsA && nCiaCsB))
    else begin
        errorCount++;
        $display("Error at %0t: ack, pad enable or select active while ts is low", $time);
    end

    // Any acknowledge is a single clock
    singleTa: assert property (@(posedge CLK40) disable iff (!nRESET) !nTA |=> nTA)
    else begin
        errorCount++;
        $display("Error at %0t: nTA stayed low for more than one cycle", $time);
    end

    ////////////////////////////////////////
    // Check helpers
    ////////////////////////////////////////

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkCount++;
        assert (actual === expected)
        else begin
            errorCount++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Error at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Space class straight from the address map
    function automatic int classify(input cycleTermPkg::addr_t addr,
                                    input cycleTermPkg::tt_t ttVal);
        // Interrupt acknowledge wins over any address
        if (ttVal == 2'd3) return SpShort;
        if ((addr & `ROM_MASK) == `ROM_BASE) return SpRom;
        if ((addr & `CIA_MASK) == `CIA_BASE) begin
            // Exactly one of A12 and A13 low
            if (addr[12] != addr[13]) return SpCia;
            return SpCiaBad;
        end
        if ((addr & `CHIP_MASK) == `CHIP_BASE) return SpRam;
        if ((addr & `REG_MASK) == `REG_BASE) return SpRam;
        if ((addr & `FAST_MASK) == `FAST_BASE) return SpRam;
        return SpShort;
    endfunction

    // nTA for the fixed-latency spaces, sample n lies between edge n and n + 1
    function automatic logic expectedTa(input int kind, input int edgeNo);
        if (kind == SpRom) return (edgeNo != `ROM_WAIT);
        if (kind == SpShort) return (edgeNo != 1);
        return 1'b1;
    endfunction

    ////////////////////////////////////////
    // Address pickers
    ////////////////////////////////////////

    function automatic cycleTermPkg::addr_t randomIn(input cycleTermPkg::addr_t base,
                                                     input cycleTermPkg::addr_t mask);
        return base | (cycleTermPkg::addr_t'($urandom) & ~mask);
    endfunction

    // sel is {A13, A12}
    function automatic cycleTermPkg::addr_t ciaAddress(input logic [1:0] sel);
        cycleTermPkg::addr_t addr;
        addr        = randomIn(`CIA_BASE, `CIA_MASK);
        addr[13:12] = sel;
        return addr;
    endfunction

    // 2xxxxxxx lies outside all five windows
    function automatic cycleTermPkg::addr_t unmappedAddress();
        return 32'h2000_0000 | (cycleTermPkg::addr_t'($urandom) & 32'h0FFF_FFFF);
    endfunction

    ////////////////////////////////////////
    // One bus cycle
    ////////////////////////////////////////

    // holdCycles keeps ts high past the ack, only for ROM and short cycles
    task automatic runCycle(input cycleTermPkg::addr_t addr, input cycleTermPkg::tt_t ttVal,
                            input int holdCycles);
        int   kind;
        int   limit;
        int   edgeNo;
        int   ackEdge;
        int   lowRun;
        bit   sawHigh;
        bit   done;
        bit   needAck;
        logic ciaWin;
        logic expOe;
        logic expRomEn;
        logic expCsA;
        logic expCsB;

        kind     = classify(addr, ttVal);
        needAck  = (kind == SpRom) || (kind == SpShort) || (kind == SpCia);
        ciaWin   = (kind == SpCia) || (kind == SpCiaBad);
        expOe    = (kind != SpRam);
        expRomEn = (kind != SpRom);
        expCsA   = !(ciaWin && !addr[12]);
        expCsB   = !(ciaWin && !addr[13]);
        case (kind)
            SpRom:   limit = `ROM_WAIT + 4;
            SpShort: limit = 4;
            SpRam:   limit = 20;
            default: limit = CiaLimit;
        endcase
        edgeNo  = 0;
        ackEdge = -1;
        lowRun  = 0;
        sawHigh = 1'b0;
        done    = 1'b0;

        @(posedge CLK40);
        #DriveDelay;
        address = addr;
        tt      = ttVal;
        ts      = 1'b1;

        while (!done) begin
            @(negedge CLK40);
            // Track CIA clock levels seen since ts rose
            if (ciaClk) begin
                sawHigh = 1'b1;
                lowRun  = 0;
            end else begin
                lowRun++;
            end
            checkBit("taOe", expOe, taOe);
            checkBit("nRomEn", expRomEn, nRomEn);
            checkBit("nCiaCsA", expCsA, nCiaCsA);
            checkBit("nCiaCsB", expCsB, nCiaCsB);
            if (ackEdge >= 0) begin
                // ts still held after the ack
                checkBit("nTA", 1'b1, nTA);
            end else if (kind == SpCia) begin
                if (!nTA) begin
                    ackEdge = edgeNo;
                    checkBit("ciaClk", 1'b0, ciaClk);
                    assert (lowRun >= 2)
                    else reportFailure("CIA ack came before two low samples of ciaClk");
                    assert (sawHigh)
                    else reportFailure("CIA ack came without ciaClk high after ts rose");
                end
            end else begin
                checkBit("nTA", expectedTa(kind, edgeNo), nTA);
                if (!nTA) ackEdge = edgeNo;
            end
            if (ackEdge >= 0) begin
                done = (edgeNo >= ackEdge + holdCycles);
            end else begin
                done = (edgeNo >= limit);
            end
            edgeNo++;
        end

        assert (!needAck || ackEdge >= 0)
        else reportFailure($sformatf("no ack for address %h tt %0d within %0d cycles",
                                     addr, ttVal, limit));

        // Master drops ts the cycle after the ack
        @(posedge CLK40);
        #DriveDelay;
        ts = 1'b0;
        @(negedge CLK40);
        checkBit("nTA", 1'b1, nTA);
        checkBit("taOe", 1'b0, taOe);
        checkBit("nRomEn", 1'b1, nRomEn);
        checkBit("nCiaCsA", 1'b1, nCiaCsA);
        checkBit("nCiaCsB", 1'b1, nCiaCsB);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int                 pick;
        cycleTermPkg::tt_t  ttPick;

        nRESET  = 1'b0;
        ts      = 1'b0;
        address = '0;
        tt      = '0;
        void'($urandom(80920));

        // Reset state, held for ResetCycles clocks
        repeat (ResetCycles) begin
            @(negedge CLK40);
            checkBit("nTA", 1'b1, nTA);
            checkBit("taOe", 1'b0, taOe);
            checkBit("ciaClk", 1'b0, ciaClk);
        end
        @(posedge CLK40);
        #DriveDelay;
        nRESET = 1'b1;
        @(negedge CLK40);
        checkBit("nTA", 1'b1, nTA);
        checkBit("taOe", 1'b0, taOe);
        checkBit("ciaClk", 1'b0, ciaClk);

        // ROM, second one holds ts past the ack
        runCycle(randomIn(`ROM_BASE, `ROM_MASK), 2'd1, 0);
        runCycle(`ROM_BASE, 2'd0, 3);
        // Unmapped and interrupt acknowledge
        runCycle(unmappedAddress(), 2'd0, 3);
        runCycle(unmappedAddress(), 2'd2, 0);
        runCycle(randomIn(`ROM_BASE, `ROM_MASK), 2'd3, 3);
        runCycle(ciaAddress(2'b10), 2'd3, 0);
        // RAM and registers, acked by other chips
        runCycle(randomIn(`CHIP_BASE, `CHIP_MASK), 2'd0, 0);
        runCycle(randomIn(`REG_BASE, `REG_MASK), 2'd1, 0);
        runCycle(randomIn(`FAST_BASE, `FAST_MASK), 2'd2, 0);
        // CIA A, CIA B, then both and neither selected
        runCycle(ciaAddress(2'b10), 2'd0, 0);
        runCycle(ciaAddress(2'b01), 2'd1, 0);
        runCycle(ciaAddress(2'b00), 2'd0, 0);
        runCycle(ciaAddress(2'b11), 2'd0, 0);

        // Random mix over all spaces
        repeat (RandomCycles) begin
            pick   = $urandom_range(6, 0);
            ttPick = cycleTermPkg::tt_t'($urandom_range(2, 0));
            case (pick)
                0: runCycle(randomIn(`ROM_BASE, `ROM_MASK), ttPick, 0);
                1: runCycle(ciaAddress($urandom_range(1, 0) ? 2'b10 : 2'b01), ttPick, 0);
                2: runCycle(randomIn(`CHIP_BASE, `CHIP_MASK), ttPick, 0);
                3: runCycle(randomIn(`REG_BASE, `REG_MASK), ttPick, 0);
                4: runCycle(randomIn(`FAST_BASE, `FAST_MASK), ttPick, 0);
                5: runCycle(unmappedAddress(), ttPick, 0);
                default: runCycle(cycleTermPkg::addr_t'($urandom), 2'd3, 0);
            endcase
        end

        repeat (2) @(posedge CLK40);
        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verilog
verilog/cycleTermPkg.sv
verilog/addressDecode.sv
verilog/ciaClockGen.sv
verilog/transferAck.sv
verilog/cycleTermTop.sv
sim/tbCycleTerm.sv

// File: run.sh
#!/bin/sh
# Build the cycle termination testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tbCycleTerm -f tb.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "Simulator exited with a nonzero status"
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
